/* files.f */
hdl/icache_pkg.sv
hdl/way_allocator.sv
hdl/cache_access.sv
hdl/cache_refill.sv
hdl/icache_top.sv
testbench/axi_lite_mem_model.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

/* testbench/icache_tests.txt */
# op addr(hex) expected_AR_handshakes backpressure_cycles
# R reads a line, F flushes the cache (other fields unused)
R 00000104 4 0
R 00000108 0 0
R 0000010C 0 3
R 00000220 4 2
R 00001050 4 0
R 00001150 4 0
R 00001250 4 0
R 00001350 4 1
R 00001450 4 0
R 00001550 4 0
R 00001650 4 0
R 00001750 4 0
R 00001850 4 0
R 00001050 4 0
R 00001854 0 2
F 00000000 0 0
R 00000104 4 0
R 00000100 0 1

/* testbench/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb import icache_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 200;

  logic       clock;
  logic       reset;
  logic       req_valid;
  logic       req_ready;
  addr_t      req_addr;
  logic       resp_valid;
  logic       resp_ready;
  addr_t      resp_addr;
  line_t      resp_line;
  logic       flush;
  logic       arvalid;
  logic       arready;
  addr_t      araddr;
  logic       rvalid;
  logic       rready;
  word_t      rdata;
  logic [1:0] rresp;

  int     error_count;
  int     reads_done;
  int     ar_pending;
  bit     timed_out;
  integer seed;
  addr_t  ar_addrs[$];

  icache_top icache_top_inst (
    .clock           (clock),
    .reset           (reset),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .req_addr_i      (req_addr),
    .resp_valid_o    (resp_valid),
    .resp_ready_i    (resp_ready),
    .resp_addr_o     (resp_addr),
    .resp_line_o     (resp_line),
    .flush_i         (flush),
    .m_axi_arvalid_o (arvalid),
    .m_axi_arready_i (arready),
    .m_axi_araddr_o  (araddr),
    .m_axi_rvalid_i  (rvalid),
    .m_axi_rready_o  (rready),
    .m_axi_rdata_i   (rdata),
    .m_axi_rresp_i   (rresp)
  );

  axi_lite_mem_model #(.LATENCY(2)) axi_lite_mem_model_inst (
    .clock     (clock),
    .reset     (reset),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  bind icache_top icache_assertions icache_assertions_inst (
    .clock        (clock),
    .reset        (reset),
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_line_i  (resp_line_o),
    .arvalid_i    (m_axi_arvalid_o),
    .arready_i    (m_axi_arready_i),
    .araddr_i     (m_axi_araddr_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // AR handshakes are sampled mid-cycle and complete on the next edge.
  // RREADY may only be high while a read is outstanding.
  always @(negedge clock) begin
    if (!reset) begin
      if (ar_pending == 0) begin
        check_flag("m_axi_rready_o", rready, 1'b0);
      end
      if (arvalid && arready) begin
        ar_addrs.push_back(araddr);
        ar_pending++;
      end
      if (rvalid && rready) begin
        ar_pending--;
      end
    end
  end

  // Reference line holds four memory words from the line base with word 0 low.
  function automatic line_t expected_line(addr_t addr);
    line_t line;
    addr_t word_addr;
    for (int k = 0; k < 4; k++) begin
      word_addr = {addr[31:4], 4'b0000} + addr_t'(4 * k);
      line[k*32 +: 32] = word_addr ^ 32'h5A5A0000;
    end
    return line;
  endfunction

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      error_count++;
      $display("[ERROR] %0t ns %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // One read from request through response transfer with optional stall.
  task automatic read_line(input addr_t addr, input int exp_ar, input int stall);
    int    ar_start;
    int    cycles;
    int    hold;
    line_t held_line;
    ar_start = ar_addrs.size();
    @(posedge clock);
    #1;
    req_valid = 1'b1;
    req_addr  = addr;
    // Ready seen mid-cycle means the transfer is on the next edge.
    cycles = 0;
    @(negedge clock);
    while (!req_ready && cycles < TIMEOUT_CYCLES) begin
      cycles++;
      @(negedge clock);
    end
    if (!req_ready) begin
      $display("Timeout: request for address %h was never accepted", addr);
      error_count++;
      timed_out = 1'b1;
      return;
    end
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    // Cycles from the accepting edge to the first valid response.
    cycles = 1;
    @(negedge clock);
    while (!resp_valid && cycles < TIMEOUT_CYCLES) begin
      cycles++;
      @(negedge clock);
    end
    if (!resp_valid) begin
      $display("Timeout: no response for address %h", addr);
      error_count++;
      timed_out = 1'b1;
      return;
    end
    if (exp_ar == 0) begin
      check_count("hit latency", cycles, 1);
    end
    held_line = resp_line;
    hold = stall + ($unsigned($random(seed)) % 3);
    repeat (hold) begin
      @(negedge clock);
      check_flag("resp_valid_o", resp_valid, 1'b1);
      check_line("resp_line_o", resp_line, held_line);
      check_flag("req_ready_o", req_ready, 1'b0);
    end
    @(posedge clock);
    #1;
    resp_ready = 1'b1;
    @(negedge clock);
    check_flag("resp_valid_o", resp_valid, 1'b1);
    check_line("resp_line_o", resp_line, expected_line(addr));
    check_addr("resp_addr_o", resp_addr, addr);
    @(posedge clock);
    #1;
    resp_ready = 1'b0;
    // Port is free again one cycle after the transfer.
    @(negedge clock);
    check_flag("req_ready_o", req_ready, 1'b1);
    check_count("AR handshakes", ar_addrs.size() - ar_start, exp_ar);
    if (ar_addrs.size() - ar_start == 4) begin
      for (int k = 0; k < 4; k++) begin
        check_addr("m_axi_araddr_o", ar_addrs[ar_start + k],
                   {addr[31:4], 4'b0000} + addr_t'(4 * k));
      end
    end
    reads_done++;
  endtask

  // Single-cycle flush pulse while the cache is idle.
  task automatic flush_cache();
    @(posedge clock);
    #1;
    flush = 1'b1;
    @(posedge clock);
    #1;
    flush = 1'b0;
  endtask

  initial begin
    int         fd;
    int         fields;
    string      text;
    logic [7:0] op;
    addr_t      addr;
    int         exp_ar;
    int         stall;
    seed        = 4;
    error_count = 0;
    reads_done  = 0;
    ar_pending  = 0;
    timed_out   = 1'b0;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_addr    = '0;
    resp_ready  = 1'b0;
    flush       = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    fd = $fopen("testbench/icache_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file testbench/icache_tests.txt");
      error_count++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        text = "";
        fields = $fgets(text, fd);
        // Skip blank and comment lines.
        if (text.len() == 0 || text[0] == "#" || text[0] == "\n") begin
          continue;
        end
        fields = $sscanf(text, "%c %h %d %d", op, addr, exp_ar, stall);
        if (fields != 4) begin
          $display("Malformed stimulus line: %s", text);
          error_count++;
        end else if (op == "R") begin
          read_line(addr, exp_ar, stall);
        end else if (op == "F") begin
          flush_cache();
        end else begin
          $display("Unknown operation in stimulus line: %s", text);
          error_count++;
        end
      end
      $fclose(fd);
    end
    if (reads_done == 0) begin
      $display("No read requests were run");
      error_count++;
    end
    $display("Errors: %0d, assertion failures: %0d", error_count,
             icache_top_inst.icache_assertions_inst.fail_count);
    if (error_count == 0 && icache_top_inst.icache_assertions_inst.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/icache_assertions.sv */
`timescale 1ns/1ns

module icache_assertions import icache_pkg::*; (
  input logic  clock,
  input logic  reset,
  input logic  req_ready_i,
  input logic  resp_valid_i,
  input logic  resp_ready_i,
  input line_t resp_line_i,
  input logic  arvalid_i,
  input logic  arready_i,
  input addr_t araddr_i
);

  int fail_count = 0;

  // A stalled response keeps its valid and its line.
  resp_stable: assert property (@(posedge clock) disable iff (reset)
      resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_line_i))
    else begin
      fail_count++;
      $error("Response dropped or changed while stalled.");
    end

  // Read address request holds until accepted.
  ar_hold: assert property (@(posedge clock) disable iff (reset)
      arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
      fail_count++;
      $error("AR request withdrawn before ARREADY.");
    end

  // No new request while a response is pending.
  // The port reopens in the cycle after the response transfers.
  no_accept_during_resp: assert property (@(posedge clock) disable iff (reset)
      resp_valid_i |-> !req_ready_i ##1 (req_ready_i == $past(resp_ready_i)))
    else begin
      fail_count++;
      $error("Request port ready while a response is pending.");
    end

endmodule

/* testbench/axi_lite_mem_model.sv */
`timescale 1ns/1ns

module axi_lite_mem_model import icache_pkg::*; #(
  parameter int LATENCY = 2
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       arvalid_i,
  output logic       arready_o,
  input  addr_t      araddr_i,
  output logic       rvalid_o,
  input  logic       rready_i,
  output word_t      rdata_o,
  output logic [1:0] rresp_o
);

  logic busy_q;
  int   wait_q;
  addr_t addr_q;

  // One read at a time, so the address channel is ready only when idle.
  assign arready_o = !busy_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q   <= 1'b0;
      rvalid_o <= 1'b0;
      wait_q   <= 0;
    end else if (!busy_q) begin
      if (arvalid_i) begin
        busy_q <= 1'b1;
        addr_q <= araddr_i;
        wait_q <= LATENCY;
      end
    end else if (rvalid_o) begin
      // Data holds until the master takes it.
      if (rready_i) begin
        rvalid_o <= 1'b0;
        busy_q   <= 1'b0;
      end
    end else if (wait_q <= 1) begin
      rvalid_o <= 1'b1;
    end else begin
      wait_q <= wait_q - 1;
    end
  end

  // Word contents are a fixed function of the byte address.
  assign rdata_o = addr_q ^ 32'h5A5A0000;
  assign rresp_o = 2'b00;

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ns

module icache_top import icache_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  addr_t      req_addr_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output addr_t      resp_addr_o,
  output line_t      resp_line_o,
  input  logic       flush_i,
  output logic       m_axi_arvalid_o,
  input  logic       m_axi_arready_i,
  output addr_t      m_axi_araddr_o,
  input  logic       m_axi_rvalid_i,
  output logic       m_axi_rready_o,
  input  word_t      m_axi_rdata_i,
  input  logic [1:0] m_axi_rresp_i
);

  logic   valid_post;
  logic   ready_post;
  logic   tar_hit;
  logic   refill_busy;
  logic   miss;
  logic   flush_gated;
  logic   wen;
  logic   advance;
  index_t windex;
  way_t   wway;
  way_t   victim;
  tag_t   wtag;
  line_t  wdata;
  addr_t  lookup_addr;

  // Response leaves only on a hit.
  assign resp_valid_o = valid_post && tar_hit;
  assign ready_post   = resp_ready_i && tar_hit;
  assign resp_addr_o  = lookup_addr;

  // Start a refill when a held request misses and the engine is free.
  assign miss = valid_post && !tar_hit && !refill_busy;

  // Flush waits until nothing is in flight.
  assign flush_gated = flush_i && req_ready_o && !refill_busy;

  cache_access cache_access_inst (
    .clock        (clock),
    .reset        (reset),
    .valid_pre_i  (req_valid_i),
    .ready_pre_o  (req_ready_o),
    .valid_post_o (valid_post),
    .ready_post_i (ready_post),
    .wen_i        (wen),
    .windex_i     (windex),
    .wway_i       (wway),
    .wtag_i       (wtag),
    .wdata_i      (wdata),
    .flush_i      (flush_gated),
    .araddr_i     (req_addr_i),
    .tar_hit_o    (tar_hit),
    .araddr_o     (lookup_addr),
    .buffer_o     (resp_line_o)
  );

  cache_refill cache_refill_inst (
    .clock           (clock),
    .reset           (reset),
    .miss_i          (miss),
    .miss_addr_i     (lookup_addr),
    .victim_i        (victim),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .wen_o           (wen),
    .windex_o        (windex),
    .wway_o          (wway),
    .wtag_o          (wtag),
    .wdata_o         (wdata),
    .advance_o       (advance),
    .busy_o          (refill_busy)
  );

  // Victim is looked up for the set being refilled.
  way_allocator way_allocator_inst (
    .clock     (clock),
    .reset     (reset),
    .advance_i (advance),
    .index_i   (windex),
    .victim_o  (victim)
  );

endmodule

/* hdl/cache_refill.sv */
`timescale 1ns/1ns

module cache_refill import icache_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       miss_i,
  input  addr_t      miss_addr_i,
  input  way_t       victim_i,
  output logic       m_axi_arvalid_o,
  input  logic       m_axi_arready_i,
  output addr_t      m_axi_araddr_o,
  input  logic       m_axi_rvalid_i,
  output logic       m_axi_rready_o,
  input  word_t      m_axi_rdata_i,
  input  logic [1:0] m_axi_rresp_i,
  output logic       wen_o,
  output index_t     windex_o,
  output way_t       wway_o,
  output tag_t       wtag_o,
  output line_t      wdata_o,
  output logic       advance_o,
  output logic       busy_o
);

  refill_state_t state_q;
  refill_state_t state_d;

  beat_t beat_q;
  addr_t line_base_q;
  line_t line_q;

  // Line base is captured when the miss starts.
  always_ff @(posedge clock) begin
    if ((state_q == REFILL_IDLE) && miss_i) begin
      line_base_q <= {miss_addr_i[31:4], 4'b0000};
    end
  end

  // Beat counter. Cleared at miss start, stepped per returned word.
  always_ff @(posedge clock) begin
    if (reset) begin
      beat_q <= '0;
    end else if ((state_q == REFILL_IDLE) && miss_i) begin
      beat_q <= '0;
    end else if ((state_q == REFILL_R) && m_axi_rvalid_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // Each word lands in its own slot of the line.
  // RRESP is not examined; the word is installed as returned.
  always_ff @(posedge clock) begin
    if ((state_q == REFILL_R) && m_axi_rvalid_i) begin
      line_q[beat_q*32 +: 32] <= m_axi_rdata_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= REFILL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      REFILL_IDLE: begin
        if (miss_i) begin
          state_d = REFILL_AR;
        end
      end
      REFILL_AR: begin
        if (m_axi_arready_i) begin
          state_d = REFILL_R;
        end
      end
      REFILL_R: begin
        // Last beat goes to the array write.
        if (m_axi_rvalid_i) begin
          state_d = (beat_q == 2'd3) ? REFILL_WRITE : REFILL_AR;
        end
      end
      REFILL_WRITE: state_d = REFILL_IDLE;
      default:      state_d = REFILL_IDLE;
    endcase
  end

  // AXI read address follows the beat number.
  assign m_axi_arvalid_o = (state_q == REFILL_AR);
  assign m_axi_araddr_o  = {line_base_q[31:4], beat_q, 2'b00};
  assign m_axi_rready_o  = (state_q == REFILL_R);

  // Array write port is driven for one cycle in REFILL_WRITE.
  assign wen_o     = (state_q == REFILL_WRITE);
  assign advance_o = (state_q == REFILL_WRITE);
  assign windex_o  = line_base_q[7:4];
  assign wtag_o    = line_base_q[31:8];
  assign wway_o    = victim_i;
  assign wdata_o   = line_q;

  assign busy_o = (state_q != REFILL_IDLE);

endmodule

/* hdl/cache_access.sv */
`timescale 1ns/1ns

module cache_access import icache_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   valid_pre_i,
  output logic   ready_pre_o,
  output logic   valid_post_o,
  input  logic   ready_post_i,
  input  logic   wen_i,
  input  index_t windex_i,
  input  way_t   wway_i,
  input  tag_t   wtag_i,
  input  line_t  wdata_i,
  input  logic   flush_i,
  input  addr_t  araddr_i,
  output logic   tar_hit_o,
  output addr_t  araddr_o,
  output line_t  buffer_o
);

  // Storage arrays hold one entry per set and way.
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  tag_t                tag_q   [NUM_SETS][NUM_WAYS];
  line_t               data_q  [NUM_SETS][NUM_WAYS];

  lookup_state_t state_q;
  lookup_state_t state_d;

  addr_t               req_addr_q;
  index_t              req_index;
  tag_t                req_tag;
  logic [NUM_WAYS-1:0] way_match;
  way_t                hit_way;

  // Request address is captured on the accepting edge.
  always_ff @(posedge clock) begin
    if (valid_pre_i && ready_pre_o) begin
      req_addr_q <= araddr_i;
    end
  end

  assign req_index = req_addr_q[7:4];
  assign req_tag   = req_addr_q[31:8];

  // Valid bits. Flush clears the whole array in one cycle.
  always_ff @(posedge clock) begin
    if (reset || flush_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (wen_i) begin
      valid_q[windex_i][wway_i] <= 1'b1;
    end
  end

  // Tag and line written together on refill.
  always_ff @(posedge clock) begin
    if (wen_i) begin
      tag_q[windex_i][wway_i]  <= wtag_i;
      data_q[windex_i][wway_i] <= wdata_i;
    end
  end

  // Compare all ways of the indexed set in parallel.
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_match[w] = valid_q[req_index][w] && (tag_q[req_index][w] == req_tag);
    end
  end

  // Lowest matching way wins, so scan downwards.
  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_match[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  // Two-state handshake control.
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= LOOKUP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOOKUP_IDLE: if (valid_pre_i)  state_d = LOOKUP_WAIT;
      LOOKUP_WAIT: if (ready_post_i) state_d = LOOKUP_IDLE;
      default:     state_d = LOOKUP_IDLE;
    endcase
  end

  assign ready_pre_o  = (state_q == LOOKUP_IDLE);
  assign valid_post_o = (state_q == LOOKUP_WAIT);

  // Hit only counts while a request is held.
  assign tar_hit_o = valid_post_o && (|way_match);
  assign araddr_o  = req_addr_q;
  assign buffer_o  = data_q[req_index][hit_way];

endmodule

/* hdl/way_allocator.sv */
`timescale 1ns/1ns

module way_allocator import icache_pkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   advance_i,
  input  index_t index_i,
  output way_t   victim_o
);

  // One round-robin pointer per set.
  way_t count_q [NUM_SETS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        count_q[s] <= '0;
      end
    end else if (advance_i) begin
      // Three bit counter wraps after way 7.
      count_q[index_i] <= count_q[index_i] + 1'b1;
    end
  end

  // Next way to replace in the selected set.
  assign victim_o = count_q[index_i];

endmodule

/* hdl/icache_pkg.sv */
package icache_pkg;

  // Byte address and AXI data word.
  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;

  // Tag in address bits 31 to 8 and set index in bits 7 to 4.
  typedef logic [23:0]  tag_t;
  typedef logic [3:0]   index_t;

  // Way number within a set.
  typedef logic [2:0]   way_t;

  // One 16 byte line with word 0 in the low bits.
  typedef logic [127:0] line_t;

  // Word position within a line during refill.
  typedef logic [1:0]   beat_t;

  // Cache geometry of 16 sets with 8 ways each.
  localparam int NUM_SETS = 16;
  localparam int NUM_WAYS = 8;

  typedef enum logic {LOOKUP_IDLE, LOOKUP_WAIT} lookup_state_t;
  typedef enum logic [1:0] {REFILL_IDLE, REFILL_AR, REFILL_R, REFILL_WRITE} refill_state_t;

endpackage
